//--- src/put_pkg.sv
/* shared widths, payload types and the intake state encoding for the put engine
   every RTL file refers to these by scoped name */
package put_pkg;

   typedef logic [0:1]   tag_t;    // tag index, sets the pool size
   typedef logic [0:2]   beat_t;   // beat within one put

   localparam int num_tags   = 2 ** $bits(tag_t);
   localparam int max_beats  = 2 ** $bits(beat_t);
   localparam int data_width = 128;

   // one beat of payload and its two even parity bits
   typedef logic [0:data_width-1] data_t;
   typedef logic [0:1]            par_t;   // bit 0 covers data[0:63], bit 1 covers data[64:127]

   typedef logic [0:63]  ea_t;     // effective address
   typedef logic [0:8]   ctxt_t;   // context id
   typedef logic [0:3]   cnt_t;    // last beat byte count, zero = 16

   // total bytes in a put, up to 128, also used as the request tsize
   typedef logic [0:7]   bcnt_t;

   typedef logic [0:0]   rc_t;     // response code, 0 = good

   typedef enum logic [1:0] {
      st_idle,   // waiting for an address and a free tag
      st_data,   // taking beats
      st_req     // request out on the bus
   } intake_state_e;

endpackage

//--- src/put_intake.sv
`timescale 1ns/1ps
/* put intake that takes one put at a time from the client, counts its beats and bytes,
   drives the data buffer writes and holds the bus request until the bus takes it */
module put_intake (
   input  logic                   clk,
   input  logic                   i_reset,

   input  logic                   put_addr_v,
   input  put_pkg::ea_t           put_addr_d_ea,
   input  put_pkg::ctxt_t         put_addr_d_ctxt,
   output logic                   put_addr_r,

   input  logic                   put_data_v,
   input  logic                   put_data_e,
   input  put_pkg::cnt_t          put_data_c,   // valid with put_data_e only
   output logic                   put_data_r,

   input  logic                   i_tag_free,
   input  put_pkg::tag_t          i_tag,
   output logic                   o_alloc,
   output logic                   o_done_len,
   output put_pkg::bcnt_t         o_len,

   output logic                   o_wr_v,
   output put_pkg::tag_t          o_wr_tag,
   output put_pkg::beat_t         o_wr_beat,

   output logic                   o_req_v,
   output put_pkg::tag_t          o_req_tag,
   output put_pkg::ea_t           o_req_ea,
   output put_pkg::ctxt_t         o_req_ctxt,
   output put_pkg::bcnt_t         o_req_tsize,
   input  logic                   o_req_r
);

   put_pkg::intake_state_e state_q;

   put_pkg::tag_t   tag_q;
   put_pkg::ea_t    ea_q;
   put_pkg::ctxt_t  ctxt_q;
   put_pkg::beat_t  beat_cnt_q;   // index of the next beat
   put_pkg::bcnt_t  len_q;        // bytes taken so far
   put_pkg::bcnt_t  beat_bytes;

   logic addr_acc;
   logic beat_acc;
   logic last_beat;
   logic req_taken;

   // no address is taken while in reset
   assign put_addr_r = (state_q == put_pkg::st_idle) & i_tag_free & ~i_reset;
   assign put_data_r = (state_q == put_pkg::st_data);

   assign addr_acc  = put_addr_v & put_addr_r;
   assign beat_acc  = put_data_v & put_data_r;
   assign req_taken = o_req_v & o_req_r;

   // the eighth beat closes the put even without put_data_e
   assign last_beat = put_data_e |
                      (beat_cnt_q == put_pkg::beat_t'(put_pkg::max_beats - 1));

   assign beat_bytes = (put_data_e && put_data_c != '0) ? put_pkg::bcnt_t'(put_data_c)
                                                         : put_pkg::bcnt_t'(16);

   always_ff @(posedge clk) begin
      if (i_reset) begin
         state_q    <= put_pkg::st_idle;
         beat_cnt_q <= '0;
         len_q      <= '0;
         o_wr_v     <= 1'b0;
         o_req_v    <= 1'b0;
      end else begin
         o_wr_v <= beat_acc;   // data lands one cycle after the beat
         if (addr_acc) begin
            beat_cnt_q <= '0;
            len_q      <= '0;
         end else if (beat_acc) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
            len_q      <= len_q + beat_bytes;
         end

         case (state_q)
            put_pkg::st_idle: begin
               if (addr_acc)
                  state_q <= put_pkg::st_data;
            end
            put_pkg::st_data: begin
               if (beat_acc && last_beat)
                  state_q <= put_pkg::st_req;
            end
            put_pkg::st_req: begin
               if (!o_req_v) begin
                  o_req_v <= 1'b1;   // byte count is final by now
               end else if (o_req_r) begin
                  o_req_v <= 1'b0;
                  state_q <= put_pkg::st_idle;
               end
            end
            default: state_q <= put_pkg::st_idle;
         endcase
      end
   end

   // put fields stay put until the next address is taken
   always_ff @(posedge clk) begin
      if (addr_acc) begin
         tag_q  <= i_tag;
         ea_q   <= put_addr_d_ea;
         ctxt_q <= put_addr_d_ctxt;
      end
      if (beat_acc)
         o_wr_beat <= beat_cnt_q;
   end

   assign o_alloc    = addr_acc;
   assign o_done_len = req_taken;   // tag manager marks the tag issued
   assign o_len      = len_q;

   assign o_wr_tag    = tag_q;
   assign o_req_tag   = tag_q;
   assign o_req_ea    = ea_q;
   assign o_req_ctxt  = ctxt_q;
   assign o_req_tsize = len_q;

endmodule

//--- src/put_data_buf.sv
`timescale 1ns/1ps
/* put data buffer: holds every beat by tag and beat index until the bus fetches it,
   checks beat parity on the way in and answers fetches one cycle later */
module put_data_buf (
   input  logic                   clk,
   input  logic                   i_reset,

   input  logic                   i_wr_v,
   input  put_pkg::tag_t          i_wr_tag,
   input  put_pkg::beat_t         i_wr_beat,
   input  logic [0:put_pkg::data_width+$bits(put_pkg::par_t)-1] i_wr_d,   // data then parity

   input  logic                   i_wdata_req_v,
   input  put_pkg::tag_t          i_wdata_req_tag,
   input  put_pkg::beat_t         i_wdata_req_beat,
   output logic                   o_wdata_rsp_v,
   output put_pkg::data_t         o_wdata_rsp_d,

   output logic                   o_perror
);

   put_pkg::data_t mem [0:put_pkg::num_tags*put_pkg::max_beats-1];

   put_pkg::par_t wr_par;
   logic          wr_perr;

   assign wr_par = i_wr_d[put_pkg::data_width +: $bits(put_pkg::par_t)];

   // even parity per 64 bit half
   assign wr_perr = i_wr_v &
                    ((^i_wr_d[0 +: put_pkg::data_width/2] ^ wr_par[0]) |
                     (^i_wr_d[put_pkg::data_width/2 +: put_pkg::data_width/2] ^ wr_par[1]));

   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_perror      <= 1'b0;
         o_wdata_rsp_v <= 1'b0;
      end else begin
         o_perror      <= o_perror | wr_perr;   // sticky until reset
         o_wdata_rsp_v <= i_wdata_req_v;
      end
   end

   always_ff @(posedge clk) begin
      if (i_wr_v)
         mem[{i_wr_tag, i_wr_beat}] <= i_wr_d[0:put_pkg::data_width-1];
      if (i_wdata_req_v)
         o_wdata_rsp_d <= mem[{i_wdata_req_tag, i_wdata_req_beat}];
   end

endmodule

//--- src/put_tag_mgr.sv
`timescale 1ns/1ps
/* put tag manager: hands out tags in ring order, records issue, response and byte count
   per tag, and retires puts to the done port in allocation order */
module put_tag_mgr (
   input  logic                   clk,
   input  logic                   i_reset,

   output logic                   o_tag_free,
   output put_pkg::tag_t          o_tag,
   input  logic                   i_alloc,
   input  logic                   i_done_len,
   input  put_pkg::bcnt_t         i_len,

   input  logic                   i_rsp_v,
   input  put_pkg::tag_t          i_rsp_tag,
   input  put_pkg::rc_t           i_rsp_rc,

   input  logic                   i_disable,
   output logic                   put_done_v,
   output put_pkg::rc_t           put_done_rc,
   output put_pkg::bcnt_t         put_done_bcnt,
   input  logic                   put_done_r,

   output logic                   o_rm_err
);

   put_pkg::tag_t alloc_ptr_q;   // next tag to hand out
   put_pkg::tag_t iss_ptr_q;     // next tag whose request goes out
   put_pkg::tag_t ret_ptr_q;     // oldest tag in use
   logic [0:2]    used_q;        // tags in use, 0 to 4

   logic [0:put_pkg::num_tags-1] issued_q;
   logic [0:put_pkg::num_tags-1] rsp_q;
   put_pkg::rc_t                 rc_q  [0:put_pkg::num_tags-1];
   put_pkg::bcnt_t               len_q [0:put_pkg::num_tags-1];

   logic disable_q;
   logic rsp_ok;
   logic head_ready;
   logic done_start;
   logic done_take;

   assign o_tag_free = (used_q != 3'(put_pkg::num_tags));
   assign o_tag      = alloc_ptr_q;

   // only a tag with its request out and no response yet may take one
   assign rsp_ok = i_rsp_v & issued_q[i_rsp_tag] & ~rsp_q[i_rsp_tag];

   assign head_ready = issued_q[ret_ptr_q] & rsp_q[ret_ptr_q];
   assign done_start = ~put_done_v & head_ready & ~disable_q;
   assign done_take  = put_done_v & put_done_r;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         alloc_ptr_q <= '0;
         iss_ptr_q   <= '0;
         ret_ptr_q   <= '0;
         used_q      <= '0;
         issued_q    <= '0;
         rsp_q       <= '0;
         disable_q   <= 1'b0;
         put_done_v  <= 1'b0;
         o_rm_err    <= 1'b0;
      end else begin
         disable_q <= i_disable;
         o_rm_err  <= i_rsp_v & ~rsp_ok;   // stray response, otherwise dropped

         if (i_alloc)
            alloc_ptr_q <= alloc_ptr_q + 1'b1;

         case ({i_alloc, done_take})
            2'b10:   used_q <= used_q + 1'b1;
            2'b01:   used_q <= used_q - 1'b1;
            default: used_q <= used_q;
         endcase

         if (i_done_len) begin
            issued_q[iss_ptr_q] <= 1'b1;
            iss_ptr_q           <= iss_ptr_q + 1'b1;
         end

         if (rsp_ok)
            rsp_q[i_rsp_tag] <= 1'b1;

         // head tag goes back to the pool when the client takes the completion
         if (done_take) begin
            issued_q[ret_ptr_q] <= 1'b0;
            rsp_q[ret_ptr_q]    <= 1'b0;
            ret_ptr_q           <= ret_ptr_q + 1'b1;
            put_done_v          <= 1'b0;
         end else if (done_start) begin
            put_done_v <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_done_len)
         len_q[iss_ptr_q] <= i_len;
      if (rsp_ok)
         rc_q[i_rsp_tag] <= i_rsp_rc;
      if (done_start) begin
         put_done_rc   <= rc_q[ret_ptr_q];
         put_done_bcnt <= len_q[ret_ptr_q];   // held while put_done_v waits
      end
   end

endmodule

//--- src/put_engine.sv
`timescale 1ns/1ps
/* put engine top: client puts go through the intake into the data buffer,
   the tag manager tracks each put from allocation to completion */
module put_engine (
   input  logic                   clk,
   input  logic                   i_reset,

   // client put interface
   input  logic                   put_addr_v,
   input  put_pkg::ea_t           put_addr_d_ea,
   input  put_pkg::ctxt_t         put_addr_d_ctxt,
   output logic                   put_addr_r,
   input  logic                   put_data_v,
   input  logic                   put_data_e,
   input  put_pkg::cnt_t          put_data_c,
   input  logic [0:put_pkg::data_width+$bits(put_pkg::par_t)-1] put_data_d,
   output logic                   put_data_r,

   // bus request
   output logic                   o_req_v,
   output put_pkg::tag_t          o_req_tag,
   output put_pkg::ea_t           o_req_ea,
   output put_pkg::ctxt_t         o_req_ctxt,
   output put_pkg::bcnt_t         o_req_tsize,
   input  logic                   o_req_r,

   // bus data fetch
   input  logic                   i_wdata_req_v,
   input  put_pkg::tag_t          i_wdata_req_tag,
   input  put_pkg::beat_t         i_wdata_req_beat,
   output logic                   o_wdata_rsp_v,
   output put_pkg::data_t         o_wdata_rsp_d,
   output logic                   o_perror,

   // bus response and completion
   input  logic                   i_rsp_v,
   input  put_pkg::tag_t          i_rsp_tag,
   input  put_pkg::rc_t           i_rsp_rc,
   input  logic                   i_disable,
   output logic                   put_done_v,
   output put_pkg::rc_t           put_done_rc,
   output put_pkg::bcnt_t         put_done_bcnt,
   input  logic                   put_done_r,
   output logic                   o_rm_err
);

   logic           tag_free;
   put_pkg::tag_t  tag;
   logic           alloc;
   logic           done_len;
   put_pkg::bcnt_t len;
   logic           wr_v;
   put_pkg::tag_t  wr_tag;
   put_pkg::beat_t wr_beat;

   put_intake u_put_intake (
      .clk(clk), .i_reset(i_reset),
      .put_addr_v(put_addr_v), .put_addr_d_ea(put_addr_d_ea),
      .put_addr_d_ctxt(put_addr_d_ctxt), .put_addr_r(put_addr_r),
      .put_data_v(put_data_v), .put_data_e(put_data_e),
      .put_data_c(put_data_c), .put_data_r(put_data_r),
      .i_tag_free(tag_free), .i_tag(tag),
      .o_alloc(alloc), .o_done_len(done_len), .o_len(len),
      .o_wr_v(wr_v), .o_wr_tag(wr_tag), .o_wr_beat(wr_beat),
      .o_req_v(o_req_v), .o_req_tag(o_req_tag), .o_req_ea(o_req_ea),
      .o_req_ctxt(o_req_ctxt), .o_req_tsize(o_req_tsize), .o_req_r(o_req_r)
   );

   // put_data_d trails the beat by a cycle, as does the write strobe
   put_data_buf u_put_data_buf (
      .clk(clk), .i_reset(i_reset),
      .i_wr_v(wr_v), .i_wr_tag(wr_tag), .i_wr_beat(wr_beat), .i_wr_d(put_data_d),
      .i_wdata_req_v(i_wdata_req_v), .i_wdata_req_tag(i_wdata_req_tag),
      .i_wdata_req_beat(i_wdata_req_beat),
      .o_wdata_rsp_v(o_wdata_rsp_v), .o_wdata_rsp_d(o_wdata_rsp_d),
      .o_perror(o_perror)
   );

   put_tag_mgr u_put_tag_mgr (
      .clk(clk), .i_reset(i_reset),
      .o_tag_free(tag_free), .o_tag(tag),
      .i_alloc(alloc), .i_done_len(done_len), .i_len(len),
      .i_rsp_v(i_rsp_v), .i_rsp_tag(i_rsp_tag), .i_rsp_rc(i_rsp_rc),
      .i_disable(i_disable),
      .put_done_v(put_done_v), .put_done_rc(put_done_rc),
      .put_done_bcnt(put_done_bcnt), .put_done_r(put_done_r),
      .o_rm_err(o_rm_err)
   );

endmodule

//--- testbench/put_engine_ref.svh
/* reference model for the put engine testbench, included inside the testbench module
   holds the byte count and parity rules and the expected request, fetch and done streams */
`ifndef PUT_ENGINE_REF_SVH
`define PUT_ENGINE_REF_SVH

typedef struct packed {
   put_pkg::tag_t  tag;
   put_pkg::ea_t   ea;
   put_pkg::ctxt_t ctxt;
   put_pkg::bcnt_t tsize;
} exp_req_t;

typedef struct packed {
   put_pkg::rc_t   rc;
   put_pkg::bcnt_t bcnt;
} exp_done_t;

exp_req_t       exp_req_q [$];     // requests in allocation order
exp_done_t      exp_done_q [$];    // completions in allocation order
put_pkg::data_t exp_fetch_q [$];   // fetch data in fetch order

// what was sent under each tag, good until the tag retires
put_pkg::data_t sent_data [0:put_pkg::num_tags-1][0:put_pkg::max_beats-1];
int             tag_nbeats [0:put_pkg::num_tags-1];
put_pkg::rc_t   tag_rc [0:put_pkg::num_tags-1];   // response code the bus returns

// full beats carry 16 bytes, a last count of zero also means 16
function automatic put_pkg::bcnt_t calc_bcnt(input int nbeats, input put_pkg::cnt_t last_cnt);
   int last_bytes;
   last_bytes = (last_cnt == 0) ? 16 : int'(last_cnt);
   return put_pkg::bcnt_t'(16 * (nbeats - 1) + last_bytes);
endfunction

function automatic put_pkg::par_t calc_par(input put_pkg::data_t d);
   put_pkg::par_t p;
   p[0] = ^d[0:63];     // even parity over the first half
   p[1] = ^d[64:127];
   return p;
endfunction

// tags leave the ring in order 0, 1, 2, 3, 0
function automatic put_pkg::tag_t tag_of(input int put_num);
   return put_pkg::tag_t'(put_num % put_pkg::num_tags);
endfunction

function automatic void record_put(input put_pkg::tag_t tag, input put_pkg::ea_t ea,
                                   input put_pkg::ctxt_t ctxt, input int nbeats,
                                   input put_pkg::cnt_t last_cnt, input put_pkg::rc_t rc);
   exp_req_t  r;
   exp_done_t d;
   r.tag   = tag;
   r.ea    = ea;
   r.ctxt  = ctxt;
   r.tsize = calc_bcnt(nbeats, last_cnt);
   exp_req_q.push_back(r);
   d.rc   = rc;
   d.bcnt = r.tsize;
   exp_done_q.push_back(d);
   tag_nbeats[tag] = nbeats;
   tag_rc[tag]     = rc;
endfunction

`endif

//--- testbench/put_engine_tb.sv
`timescale 1ns/1ps
/* testbench for the put engine where a client, a bus model and a done sink run against the DUT
   while a compare process checks requests, fetches and completions against the reference */
module put_engine_tb;

   localparam int total_puts = 27;   // sum of puts over all tests

   logic clk = 1'b0;
   logic i_reset;
   logic put_addr_v, put_addr_r, put_data_v, put_data_e, put_data_r;
   put_pkg::ea_t   put_addr_d_ea;
   put_pkg::ctxt_t put_addr_d_ctxt;
   put_pkg::cnt_t  put_data_c;
   logic [0:put_pkg::data_width+$bits(put_pkg::par_t)-1] put_data_d;
   logic o_req_v, o_req_r, i_wdata_req_v, o_wdata_rsp_v, o_perror;
   put_pkg::tag_t  o_req_tag, i_wdata_req_tag, i_rsp_tag;
   put_pkg::ea_t   o_req_ea;
   put_pkg::ctxt_t o_req_ctxt;
   put_pkg::bcnt_t o_req_tsize, put_done_bcnt;
   put_pkg::beat_t i_wdata_req_beat;
   put_pkg::data_t o_wdata_rsp_d;
   logic i_rsp_v, i_disable, put_done_v, put_done_r, o_rm_err;
   put_pkg::rc_t   i_rsp_rc, put_done_rc;

   `include "put_engine_ref.svh"

   int seed = 32'h57c27575;
   int err_cnt = 0;
   int check_cnt = 0;
   int tests_run = 0;
   int tests_failed = 0;
   int test_err_start = 0;
   int sent_cnt = 0;
   int alloc_cnt = 0;
   int done_cnt = 0;
   int rsp_cnt = 0;
   int rm_cnt = 0;
   int stray_cnt = 0;
   bit bad_driven = 1'b0;
   bit perr_seen = 1'b0;
   bit stray_req = 1'b0;
   put_pkg::tag_t stray_tag;

   // values from the previous edge for the hold and timing checks
   bit prev_req_v = 1'b0, prev_req_r = 1'b0, prev_done_v = 1'b0, prev_done_r = 1'b0;
   bit prev_fetch_v = 1'b0, dis_1 = 1'b0, dis_2 = 1'b0;
   exp_req_t  prev_req;
   exp_done_t prev_done;

   put_engine u_put_engine (
      .clk(clk), .i_reset(i_reset),
      .put_addr_v(put_addr_v), .put_addr_d_ea(put_addr_d_ea),
      .put_addr_d_ctxt(put_addr_d_ctxt), .put_addr_r(put_addr_r),
      .put_data_v(put_data_v), .put_data_e(put_data_e), .put_data_c(put_data_c),
      .put_data_d(put_data_d), .put_data_r(put_data_r),
      .o_req_v(o_req_v), .o_req_tag(o_req_tag), .o_req_ea(o_req_ea),
      .o_req_ctxt(o_req_ctxt), .o_req_tsize(o_req_tsize), .o_req_r(o_req_r),
      .i_wdata_req_v(i_wdata_req_v), .i_wdata_req_tag(i_wdata_req_tag),
      .i_wdata_req_beat(i_wdata_req_beat), .o_wdata_rsp_v(o_wdata_rsp_v),
      .o_wdata_rsp_d(o_wdata_rsp_d), .o_perror(o_perror),
      .i_rsp_v(i_rsp_v), .i_rsp_tag(i_rsp_tag), .i_rsp_rc(i_rsp_rc), .i_disable(i_disable),
      .put_done_v(put_done_v), .put_done_rc(put_done_rc), .put_done_bcnt(put_done_bcnt),
      .put_done_r(put_done_r), .o_rm_err(o_rm_err)
   );

   always #2 clk = ~clk;   // 4 ns period

   task automatic note_mismatch(input string msg);
      $display("Mismatch at %0t: %s", $time, msg);
      err_cnt++;
   endtask

   task automatic note_failure(input string msg);
      $display("error at %0t: %s", $time, msg);
      err_cnt++;
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (err_cnt != test_err_start)
         tests_failed++;
      $display("test %s: %s, %0d errors", name, (err_cnt == test_err_start) ? "ok" : "FAILED",
               err_cnt - test_err_start);
      test_err_start = err_cnt;
   endtask

   // sends one put of random shape, optionally with one beat of bad parity
   task automatic send_put(input bit flip_par);
      put_pkg::ea_t   ea;
      put_pkg::ctxt_t ctxt;
      put_pkg::cnt_t  last_cnt;
      put_pkg::rc_t   rc;
      put_pkg::tag_t  tag;
      put_pkg::data_t d;
      put_pkg::par_t  p;
      int             nbeats;
      int             bad_beat;
      ea       = {$urandom, $urandom};
      ctxt     = put_pkg::ctxt_t'($urandom);
      last_cnt = put_pkg::cnt_t'($urandom);
      rc       = put_pkg::rc_t'($urandom);
      nbeats   = 1 + $urandom % put_pkg::max_beats;
      bad_beat = flip_par ? int'($urandom % nbeats) : -1;
      repeat ($urandom % 3) begin
         @(posedge clk);
         #1;
      end
      put_addr_d_ea   = ea;
      put_addr_d_ctxt = ctxt;
      put_addr_v      = 1'b1;
      @(posedge clk);
      while (!put_addr_r)
         @(posedge clk);
      tag = tag_of(sent_cnt);
      record_put(tag, ea, ctxt, nbeats, last_cnt, rc);
      sent_cnt++;
      #1;
      put_addr_v = 1'b0;
      for (int b = 0; b < nbeats; b++) begin
         d = {$urandom, $urandom, $urandom, $urandom};
         sent_data[tag][b] = d;
         put_data_v = 1'b1;
         put_data_e = (b == nbeats - 1);
         put_data_c = put_data_e ? last_cnt : put_pkg::cnt_t'($urandom);
         @(posedge clk);
         while (!put_data_r)
            @(posedge clk);
         #1;
         p = calc_par(d);   // payload follows its beat by one cycle
         if (b == bad_beat) begin
            p[0]       = ~p[0];
            bad_driven = 1'b1;
         end
         put_data_d = {d, p};
         put_data_v = 1'b0;
         put_data_e = 1'b0;
      end
   endtask

   task automatic drain();
      wait (done_cnt == sent_cnt);
      repeat (4) @(posedge clk);
      #1;
   endtask

   initial begin : main
      void'($urandom(seed));
      i_reset = 1'b1;
      put_addr_v = 1'b0;
      put_addr_d_ea = '0;
      put_addr_d_ctxt = '0;
      put_data_v = 1'b0;
      put_data_e = 1'b0;
      put_data_c = '0;
      put_data_d = '0;
      i_disable = 1'b0;
      repeat (5) @(posedge clk);
      #1;
      check_cnt++;
      assert (!(put_addr_r | put_data_r | o_req_v | put_done_v | o_wdata_rsp_v | o_rm_err |
                o_perror))
         else note_failure("outputs not low after reset");
      i_reset = 1'b0;
      end_test("reset");

      repeat (16) send_put(1'b0);
      drain();
      end_test("in-order traffic");

      i_disable = 1'b1;   // four puts fill the pool and stay parked
      repeat (4) send_put(1'b0);
      wait (rsp_cnt == sent_cnt);
      repeat (20) @(posedge clk);
      #1;
      check_cnt++;
      assert (done_cnt == sent_cnt - 4 && !put_done_v)
         else note_failure("a put completed while i_disable was high");
      i_disable = 1'b0;
      drain();
      end_test("disable gate");

      send_put(1'b0);
      send_put(1'b1);
      send_put(1'b0);
      drain();
      check_cnt++;
      assert (o_perror) else note_failure("o_perror not set after a beat with bad parity");
      end_test("parity error");

      stray_tag = put_pkg::tag_t'($urandom);   // no tag is waiting since the pool is empty
      stray_req = 1'b1;
      wait (!stray_req);
      repeat (4) send_put(1'b0);
      drain();
      check_cnt++;
      assert (rm_cnt == 1 && stray_cnt == 1)
         else note_failure("o_rm_err did not pulse once for the stray response");
      end_test("stray response");

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, check_cnt, err_cnt);
      if (err_cnt == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

   // bus model that takes requests, fetches every beat, then answers in shuffled order
   initial begin : bus
      put_pkg::tag_t fetch_q [$];
      put_pkg::tag_t rsp_pend [$];
      put_pkg::tag_t t;
      int            cur_beat;
      int            idx;
      cur_beat = 0;
      o_req_r = 1'b0;
      i_wdata_req_v = 1'b0;
      i_wdata_req_tag = '0;
      i_wdata_req_beat = '0;
      i_rsp_v = 1'b0;
      i_rsp_tag = '0;
      i_rsp_rc = '0;
      forever begin
         @(posedge clk);
         if (!i_reset && o_req_v && o_req_r)
            fetch_q.push_back(o_req_tag);
         #1;
         o_req_r       = $urandom % 2;
         i_wdata_req_v = 1'b0;
         i_rsp_v       = 1'b0;
         if (fetch_q.size() > 0 && $urandom % 4 != 0) begin
            t = fetch_q[0];
            i_wdata_req_v    = 1'b1;
            i_wdata_req_tag  = t;
            i_wdata_req_beat = put_pkg::beat_t'(cur_beat);
            exp_fetch_q.push_back(sent_data[t][cur_beat]);
            cur_beat++;
            if (cur_beat == tag_nbeats[t]) begin
               cur_beat = 0;
               void'(fetch_q.pop_front());
               rsp_pend.push_back(t);
            end
         end
         if (rsp_pend.size() > 0 && ($urandom % 4 == 0 || rsp_pend.size() > 2)) begin
            idx       = $urandom % rsp_pend.size();
            i_rsp_v   = 1'b1;
            i_rsp_tag = rsp_pend[idx];
            i_rsp_rc  = tag_rc[rsp_pend[idx]];
            rsp_pend.delete(idx);
            rsp_cnt++;
         end else if (stray_req) begin
            i_rsp_v   = 1'b1;
            i_rsp_tag = stray_tag;
            i_rsp_rc  = 1'b1;
            stray_cnt++;
            stray_req = 1'b0;
         end
      end
   end

   initial begin : done_sink
      put_done_r = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         put_done_r = $urandom % 2;
      end
   end

   always @(posedge clk) begin : compare
      exp_req_t       er;
      exp_req_t       cur_req;
      exp_done_t      ed;
      exp_done_t      cur_done;
      put_pkg::data_t fd;
      if (!i_reset) begin
         cur_req  = {o_req_tag, o_req_ea, o_req_ctxt, o_req_tsize};
         cur_done = {put_done_rc, put_done_bcnt};
         if (alloc_cnt - done_cnt == put_pkg::num_tags) begin
            check_cnt++;
            assert (!put_addr_r) else note_failure("put_addr_r high with every tag in use");
         end
         if (put_addr_v && put_addr_r)
            alloc_cnt++;
         if (prev_req_v && !prev_req_r) begin
            check_cnt++;
            assert (o_req_v && cur_req == prev_req)
               else note_mismatch("request dropped or changed before o_req_r");
         end
         if (o_req_v && o_req_r) begin
            check_cnt++;
            assert (exp_req_q.size() > 0)
               else note_failure("request issued with no put outstanding");
            if (exp_req_q.size() > 0) begin
               er = exp_req_q.pop_front();
               check_cnt++;
               assert (cur_req == er) else note_mismatch($sformatf(
                  "request tag %0d ea %h ctxt %h tsize %0d, expected %0d %h %h %0d",
                  o_req_tag, o_req_ea, o_req_ctxt, o_req_tsize, er.tag, er.ea, er.ctxt, er.tsize));
            end
         end
         check_cnt++;
         assert (o_wdata_rsp_v == prev_fetch_v)
            else note_failure("fetch answer not exactly one cycle after the fetch");
         if (o_wdata_rsp_v) begin
            check_cnt++;
            assert (exp_fetch_q.size() > 0)
               else note_failure("fetch answer with no fetch outstanding");
            if (exp_fetch_q.size() > 0) begin
               fd = exp_fetch_q.pop_front();
               check_cnt++;
               assert (o_wdata_rsp_d == fd)
                  else note_mismatch($sformatf("fetch data %h, expected %h", o_wdata_rsp_d, fd));
            end
         end
         if (prev_done_v && !prev_done_r) begin
            check_cnt++;
            assert (put_done_v && cur_done == prev_done)
               else note_mismatch("completion dropped or changed before put_done_r");
         end
         if (put_done_v && !prev_done_v) begin
            check_cnt++;
            assert (!dis_2) else note_failure("completion started while i_disable was high");
         end
         if (put_done_v && put_done_r) begin
            done_cnt++;
            check_cnt++;
            assert (exp_done_q.size() > 0)
               else note_failure("completion with no put outstanding");
            if (exp_done_q.size() > 0) begin
               ed = exp_done_q.pop_front();
               check_cnt++;
               assert (cur_done == ed) else note_mismatch($sformatf(
                  "completion rc %0d bcnt %0d, expected rc %0d bcnt %0d",
                  put_done_rc, put_done_bcnt, ed.rc, ed.bcnt));
            end
         end
         if (o_perror) begin
            check_cnt++;
            assert (bad_driven) else note_failure("o_perror set by traffic with good parity");
            perr_seen = 1'b1;
         end else begin
            assert (!perr_seen) else note_failure("o_perror cleared without a reset");
         end
         if (o_rm_err) begin
            rm_cnt++;
            check_cnt++;
            assert (rm_cnt <= stray_cnt) else note_failure("o_rm_err pulsed with no stray response");
         end
         dis_2        = dis_1;   // i_disable is registered inside the DUT
         dis_1        = i_disable;
         prev_req_v   = o_req_v;
         prev_req_r   = o_req_r;
         prev_req     = cur_req;
         prev_done_v  = put_done_v;
         prev_done_r  = put_done_r;
         prev_done    = cur_done;
         prev_fetch_v = i_wdata_req_v;
      end
   end

   initial begin : watchdog
      #(total_puts * 200 + 2000);
      $display("timeout: run stopped after %0d ns with %0d of %0d puts completed",
               total_puts * 200 + 2000, done_cnt, total_puts);
      $display("Testbench failed");
      $finish;
   end

endmodule

//--- files.f
+incdir+testbench
src/put_pkg.sv
src/put_intake.sv
src/put_data_buf.sv
src/put_tag_mgr.sv
src/put_engine.sv
testbench/put_engine_tb.sv
